/* rle_pkg.sv */
`default_nettype none

package rle_pkg;

    // line geometry
    localparam int LINE_BYTES = 64;
    localparam int QUARTER_BYTES = 16;

    // entry layout: byte value on top, run length minus one below
    localparam int ENTRY_W = 14;
    localparam int RUN_W = 6;

    // 0..64 entries per line, 0..16 per quarter
    localparam int COUNT_W = 7;
    localparam int QCOUNT_W = 5;

    // address_in codes for the four quarters, lowest bytes first
    localparam logic [2:0] ADDR_Q0 = 3'd3;
    localparam logic [2:0] ADDR_Q1 = 3'd4;
    localparam logic [2:0] ADDR_Q2 = 3'd5;
    localparam logic [2:0] ADDR_Q3 = 3'd6;

    typedef logic [7:0] byte_t;
    typedef logic [ENTRY_W-1:0] entry_t;
    typedef logic [RUN_W-1:0] run_len_t;
    typedef logic [COUNT_W-1:0] count_t;
    typedef logic [QCOUNT_W-1:0] qcount_t;
    typedef logic [QUARTER_BYTES*8-1:0] quarter_t;
    typedef logic [LINE_BYTES*8-1:0] line_t;
    typedef logic [LINE_BYTES*ENTRY_W-1:0] packed_line_t;

    // end of list marker; an all 0xff line encodes to the same value
    localparam entry_t TERMINATOR = '1;

    // seq_qN means quarter N is the next one expected
    typedef enum logic [1:0] {
        seq_idle,
        seq_q1,
        seq_q2,
        seq_q3
    } seq_state_t;

endpackage

`default_nettype wire

/* quarter_runs_if.sv */
`default_nettype none

interface quarter_runs_if;

    // runs of the registered quarter, entry 0 first
    rle_pkg::entry_t entries [rle_pkg::QUARTER_BYTES];
    rle_pkg::qcount_t count;

    // sequencing pulses, aligned with the registered quarter
    logic valid;
    logic first;
    logic last;

    // first run of this quarter continues the last stored run
    logic join_run;

    modport encoder (
        output entries,
        output count,
        input  valid
    );

    modport sequencer (
        output valid,
        output first,
        output last
    );

    modport accumulator (
        input  entries,
        input  count,
        input  valid,
        input  first,
        input  last,
        output join_run
    );

    modport counter (
        input  count,
        input  valid,
        input  first,
        input  join_run
    );

endinterface

`default_nettype wire

/* quarter_encoder.sv */
`default_nettype none

module quarter_encoder (
    input  wire                 clk,
    input  wire                 reset,
    input  wire rle_pkg::line_t data_in,
    input  wire [2:0]           address_in,
    quarter_runs_if.encoder     runs
);

    rle_pkg::quarter_t quarter_q;
    rle_pkg::count_t covered;

    // quarter register holds its value on any other address
    always_ff @(posedge clk) begin
        case (address_in)
            rle_pkg::ADDR_Q0: begin
                quarter_q <= data_in[0*rle_pkg::QUARTER_BYTES*8 +: rle_pkg::QUARTER_BYTES*8];
            end
            rle_pkg::ADDR_Q1: begin
                quarter_q <= data_in[1*rle_pkg::QUARTER_BYTES*8 +: rle_pkg::QUARTER_BYTES*8];
            end
            rle_pkg::ADDR_Q2: begin
                quarter_q <= data_in[2*rle_pkg::QUARTER_BYTES*8 +: rle_pkg::QUARTER_BYTES*8];
            end
            rle_pkg::ADDR_Q3: begin
                quarter_q <= data_in[3*rle_pkg::QUARTER_BYTES*8 +: rle_pkg::QUARTER_BYTES*8];
            end
            default: begin
            end
        endcase
    end

    // scan byte 0 upward, closing a run wherever the byte changes
    always_comb begin
        rle_pkg::qcount_t n;
        rle_pkg::byte_t run_byte;
        rle_pkg::run_len_t run_len;
        rle_pkg::byte_t cur;

        n = '0;
        run_byte = quarter_q[7:0];
        run_len = '0;
        for (int i = 0; i < rle_pkg::QUARTER_BYTES; i++) begin
            runs.entries[i] = '0;
        end
        for (int j = 1; j < rle_pkg::QUARTER_BYTES; j++) begin
            cur = quarter_q[8*j +: 8];
            if (cur == run_byte) begin
                run_len = run_len + 1'b1;
            end else begin
                runs.entries[n[3:0]] = {run_byte, run_len};
                n = n + 1'b1;
                run_byte = cur;
                run_len = '0;
            end
        end
        // the run still open at byte 15
        runs.entries[n[3:0]] = {run_byte, run_len};
        runs.count = n + 1'b1;
    end

    // bytes covered by the emitted runs
    always_comb begin
        covered = '0;
        for (int i = 0; i < rle_pkg::QUARTER_BYTES; i++) begin
            if (i < int'(runs.count)) begin
                covered = covered + 1'b1 +
                          rle_pkg::count_t'(runs.entries[i][rle_pkg::RUN_W-1:0]);
            end
        end
    end

    // the runs of a valid quarter cover its 16 bytes exactly
    run_cover: assert property (
        @(posedge clk) disable iff (!reset)
        runs.valid |-> (covered == rle_pkg::count_t'(rle_pkg::QUARTER_BYTES))
    );

endmodule

`default_nettype wire

/* line_sequencer.sv */
`default_nettype none

module line_sequencer (
    input  wire              clk,
    input  wire              reset,
    input  wire [2:0]        address_in,
    quarter_runs_if.sequencer runs
);

    rle_pkg::seq_state_t state;
    rle_pkg::seq_state_t state_next;
    logic accept;

    // any break in the order drops back to idle
    always_comb begin
        state_next = rle_pkg::seq_idle;
        accept = 1'b0;
        case (address_in)
            rle_pkg::ADDR_Q0: begin
                // a new line may start from any state
                state_next = rle_pkg::seq_q1;
                accept = 1'b1;
            end
            rle_pkg::ADDR_Q1: begin
                if (state == rle_pkg::seq_q1) begin
                    state_next = rle_pkg::seq_q2;
                    accept = 1'b1;
                end
            end
            rle_pkg::ADDR_Q2: begin
                if (state == rle_pkg::seq_q2) begin
                    state_next = rle_pkg::seq_q3;
                    accept = 1'b1;
                end
            end
            rle_pkg::ADDR_Q3: begin
                if (state == rle_pkg::seq_q3) begin
                    state_next = rle_pkg::seq_idle;
                    accept = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= rle_pkg::seq_idle;
            runs.valid <= 1'b0;
            runs.first <= 1'b0;
            runs.last <= 1'b0;
        end else begin
            state <= state_next;
            runs.valid <= accept;
            runs.first <= (address_in == rle_pkg::ADDR_Q0);
            runs.last <= accept && (address_in == rle_pkg::ADDR_Q3);
        end
    end

    // a last pulse closes a line whose first quarter came three cycles earlier
    last_after_first: assert property (
        @(posedge clk) disable iff (!reset)
        runs.last |-> $past(runs.first, 3)
    );

endmodule

`default_nettype wire

/* entry_counter.sv */
`default_nettype none

module entry_counter (
    input  wire              clk,
    input  wire              reset,
    quarter_runs_if.counter  runs,
    output rle_pkg::count_t  total
);

    rle_pkg::count_t base;
    rle_pkg::count_t sum;

    // first quarter of a line starts from an empty list
    assign base = runs.first ? '0 : total;

    // a joined run lands in an existing slot
    assign sum = base + rle_pkg::count_t'(runs.count) - rle_pkg::count_t'(runs.join_run);

    always_ff @(posedge clk) begin
        if (!reset) begin
            total <= '0;
        end else if (runs.valid) begin
            total <= sum;
        end
    end

    // joins across borders must keep a line within one slot per byte
    total_bound: assert property (
        @(posedge clk) disable iff (!reset)
        total <= rle_pkg::count_t'(rle_pkg::LINE_BYTES)
    );

endmodule

`default_nettype wire

/* run_accumulator.sv */
`default_nettype none

module run_accumulator (
    input  wire                    clk,
    input  wire                    reset,
    quarter_runs_if.accumulator    runs,
    input  wire rle_pkg::count_t   total,
    output rle_pkg::packed_line_t  encoded_data,
    output logic                   line_done
);

    rle_pkg::entry_t slots [rle_pkg::LINE_BYTES];

    rle_pkg::count_t base;
    rle_pkg::count_t last_idx;
    rle_pkg::byte_t last_byte;
    rle_pkg::run_len_t last_len;
    rle_pkg::byte_t new_byte;
    rle_pkg::run_len_t new_len;
    rle_pkg::packed_line_t packed_next;
    logic pack_pending;

    // slot index for quarter entry i
    function automatic logic [5:0] slot_at(rle_pkg::count_t start, int i, logic skip);
        rle_pkg::count_t idx;

        idx = start + rle_pkg::count_t'(i) - rle_pkg::count_t'(skip);
        return idx[5:0];
    endfunction

    assign base = runs.first ? '0 : total;
    assign last_idx = total - 1'b1;
    assign last_byte = slots[last_idx[5:0]][rle_pkg::ENTRY_W-1:rle_pkg::RUN_W];
    assign last_len = slots[last_idx[5:0]][rle_pkg::RUN_W-1:0];
    assign new_byte = runs.entries[0][rle_pkg::ENTRY_W-1:rle_pkg::RUN_W];
    assign new_len = runs.entries[0][rle_pkg::RUN_W-1:0];

    // same byte on both sides of the border
    assign runs.join_run = !runs.first && (total != '0) && (last_byte == new_byte);

    always_ff @(posedge clk) begin
        if (runs.valid) begin
            if (runs.join_run) begin
                // lengths are stored minus one, so add one back
                slots[last_idx[5:0]] <= {last_byte, last_len + new_len + 1'b1};
            end
            for (int i = 0; i < rle_pkg::QUARTER_BYTES; i++) begin
                if (i >= int'(runs.join_run) && i < int'(runs.count)) begin
                    slots[slot_at(base, i, runs.join_run)] <= runs.entries[i];
                end
            end
        end
    end

    // entry 0 in the top slot, terminator right after the last entry
    always_comb begin
        packed_next = '0;
        for (int s = 0; s < rle_pkg::LINE_BYTES; s++) begin
            if (s < int'(total)) begin
                packed_next[(rle_pkg::LINE_BYTES-1-s)*rle_pkg::ENTRY_W +: rle_pkg::ENTRY_W] =
                    slots[s];
            end else if (s == int'(total)) begin
                packed_next[(rle_pkg::LINE_BYTES-1-s)*rle_pkg::ENTRY_W +: rle_pkg::ENTRY_W] =
                    rle_pkg::TERMINATOR;
            end
        end
    end

    // last quarter is appended one edge before packing
    always_ff @(posedge clk) begin
        if (!reset) begin
            pack_pending <= 1'b0;
            line_done <= 1'b0;
            encoded_data <= '0;
        end else begin
            pack_pending <= runs.valid && runs.last;
            line_done <= pack_pending;
            if (pack_pending) begin
                encoded_data <= packed_next;
            end
        end
    end

endmodule

`default_nettype wire

/* rle_line_encoder.sv */
`default_nettype none

module rle_line_encoder (
    input  wire                         clk,
    input  wire                         reset,
    input  wire rle_pkg::line_t         data_in,
    input  wire [2:0]                   address_in,
    output wire rle_pkg::packed_line_t  encoded_data,
    output wire                         line_done
);

    quarter_runs_if runs ();

    // entries collected so far for the line being built
    rle_pkg::count_t total;

    quarter_encoder u_encoder (
        .clk        (clk),
        .reset      (reset),
        .data_in    (data_in),
        .address_in (address_in),
        .runs       (runs.encoder)
    );

    line_sequencer u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .address_in (address_in),
        .runs       (runs.sequencer)
    );

    entry_counter u_counter (
        .clk   (clk),
        .reset (reset),
        .runs  (runs.counter),
        .total (total)
    );

    run_accumulator u_accumulator (
        .clk          (clk),
        .reset        (reset),
        .runs         (runs.accumulator),
        .total        (total),
        .encoded_data (encoded_data),
        .line_done    (line_done)
    );

endmodule

`default_nettype wire

/* rle_line_encoder_tb.sv */
`default_nettype none

module rle_line_encoder_tb;

    // 4 directed lines, 50 random, 1 after the broken order, and a broken partial line
    localparam int NUM_LINES = 56;
    localparam int MAX_CYCLES = NUM_LINES * 20 + 100;
    localparam int NUM_RANDOM = 50;

    logic clk;
    logic reset;
    rle_pkg::line_t data_in;
    logic [2:0] address_in;
    rle_pkg::packed_line_t encoded_data;
    wire line_done;

    int cyc;
    int errors;
    int checks;
    logic checking;
    logic [31:0] rng;
    rle_pkg::packed_line_t held_data;

    // expected lines and the cycle at which each one is due
    rle_pkg::packed_line_t exp_q [$];
    int due_q [$];

    rle_line_encoder rle_line_encoder_inst (
        .clk          (clk),
        .reset        (reset),
        .data_in      (data_in),
        .address_in   (address_in),
        .encoded_data (encoded_data),
        .line_done    (line_done)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;

        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] pick_symbol(input logic [1:0] k);
        logic [7:0] s;

        case (k)
            2'd0: s = 8'h00;
            2'd1: s = 8'h5a;
            2'd2: s = 8'ha5;
            default: s = 8'hff;
        endcase
        return s;
    endfunction

    // byte stays the same most of the time, so runs cross the borders often
    function automatic rle_pkg::line_t random_line();
        rle_pkg::line_t l;
        logic [7:0] cur;

        rng = xorshift32(rng);
        cur = pick_symbol(rng[1:0]);
        for (int i = 0; i < rle_pkg::LINE_BYTES; i++) begin
            rng = xorshift32(rng);
            if (rng[3:2] == 2'd0) begin
                cur = pick_symbol(rng[1:0]);
            end
            l[8*i +: 8] = cur;
        end
        return l;
    endfunction

    // expected packed line straight from the byte stream
    function automatic rle_pkg::packed_line_t ref_encode(input rle_pkg::line_t l);
        logic [rle_pkg::ENTRY_W-1:0] ents [rle_pkg::LINE_BYTES];
        int n;
        int run;
        logic [7:0] cur;
        logic [7:0] b;
        rle_pkg::packed_line_t res;

        n = 0;
        run = 1;
        cur = l[7:0];
        for (int i = 1; i < rle_pkg::LINE_BYTES; i++) begin
            b = l[8*i +: 8];
            if (b == cur) begin
                run++;
            end else begin
                ents[n] = {cur, 6'(run - 1)};
                n++;
                cur = b;
                run = 1;
            end
        end
        ents[n] = {cur, 6'(run - 1)};
        n++;

        // shift slots in from the bottom so entry 0 ends up on top
        res = '0;
        for (int s = 0; s < rle_pkg::LINE_BYTES; s++) begin
            res = res << rle_pkg::ENTRY_W;
            if (s < n) begin
                res[rle_pkg::ENTRY_W-1:0] = ents[s];
            end else if (s == n) begin
                res[rle_pkg::ENTRY_W-1:0] = '1;
            end
        end
        return res;
    endfunction

    task automatic check_value(input string name, input rle_pkg::packed_line_t got,
                               input rle_pkg::packed_line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic send_line(input rle_pkg::line_t l);
        @(negedge clk);
        data_in = l;
        address_in = rle_pkg::ADDR_Q0;
        @(negedge clk);
        address_in = rle_pkg::ADDR_Q1;
        @(negedge clk);
        address_in = rle_pkg::ADDR_Q2;
        @(negedge clk);
        address_in = rle_pkg::ADDR_Q3;
        // output is due two edges after this address is sampled
        exp_q.push_back(ref_encode(l));
        due_q.push_back(cyc + 3);
    endtask

    // quarters 0 and 1, then an address that is no quarter
    task automatic break_line(input rle_pkg::line_t l);
        @(negedge clk);
        data_in = l;
        address_in = rle_pkg::ADDR_Q0;
        @(negedge clk);
        address_in = rle_pkg::ADDR_Q1;
        @(negedge clk);
        address_in = 3'd2;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            address_in = 3'd0;
        end
    endtask

    // outputs hold between lines, and line_done only shows up when due
    always @(negedge clk) begin
        if (checking) begin
            if (due_q.size() != 0 && due_q[0] == cyc) begin
                check_value("line_done", rle_pkg::packed_line_t'(line_done),
                            rle_pkg::packed_line_t'(1));
                check_value("encoded_data", encoded_data, exp_q[0]);
                held_data = exp_q[0];
                void'(due_q.pop_front());
                void'(exp_q.pop_front());
            end else begin
                check_value("line_done", rle_pkg::packed_line_t'(line_done), '0);
                check_value("encoded_data", encoded_data, held_data);
            end
        end
    end

    initial begin
        rle_pkg::line_t l;

        cyc = 0;
        errors = 0;
        checks = 0;
        checking = 1'b0;
        held_data = '0;
        rng = 32'd12;
        reset = 1'b0;
        data_in = '0;
        address_in = 3'd0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        checking = 1'b1;
        idle(3);

        // 64 distinct bytes, then one repeated byte
        for (int i = 0; i < rle_pkg::LINE_BYTES; i++) begin
            l[8*i +: 8] = 8'(i * 3 + 7);
        end
        send_line(l);
        send_line({rle_pkg::LINE_BYTES{8'h5a}});
        idle(2);

        // 20 bytes then 44 bytes, a run over each border
        for (int i = 0; i < rle_pkg::LINE_BYTES; i++) begin
            l[8*i +: 8] = (i < 20) ? 8'h3c : 8'hc3;
        end
        send_line(l);
        // entry equals the terminator here
        send_line({rle_pkg::LINE_BYTES{8'hff}});
        idle(2);

        for (int k = 0; k < NUM_RANDOM; k++) begin
            send_line(random_line());
        end
        idle(2);

        break_line(random_line());
        idle(4);
        send_line(random_line());

        while (due_q.size() != 0) begin
            @(negedge clk);
        end
        idle(4);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rle_line_encoder.f */
rle_pkg.sv
quarter_runs_if.sv
quarter_encoder.sv
line_sequencer.sv
entry_counter.sv
run_accumulator.sv
rle_line_encoder.sv
rle_line_encoder_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= rle_line_encoder_tb
FILELIST ?= rle_line_encoder.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= === PASS ===

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
